// ==== design/axi4_read_nd_cfg.svh ====
// --------------------------------------
//  axi4 2d reader widths
//  bus, line and FIFO sizing
// --------------------------------------

`ifndef AXI4_READ_ND_CFG_SVH
`define AXI4_READ_ND_CFG_SVH

// AXI side
`define AXI_ADDR_WIDTH        32
`define AXI_DATA_WIDTH        32
`define AXI_LEN_WIDTH         8
`define BEAT_BYTES            4

// frame geometry, both stored minus one
`define LINE_LEN_WIDTH        12
`define LINE_CNT_WIDTH        12

// queue depths as log2
`define CMD_FIFO_DEPTH_LOG2   2
`define LINE_FIFO_DEPTH_LOG2  4

`endif

// ==== design/axi4_read_nd_pkg.sv ====
// --------------------------------------
//  axi4 2d reader types
//  command, line record and stream flags
// --------------------------------------

`include "axi4_read_nd_cfg.svh"

package axi4_read_nd_pkg;

    typedef struct packed {
        logic first;
        logic last;
    } flag_pair_t;

    // line position in the upper pair, beat position in the lower
    typedef struct packed {
        flag_pair_t line;
        flag_pair_t beat;
    } beat_flags_t;

    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_ADDR_WIDTH-1:0] step;
        logic [`LINE_LEN_WIDTH-1:0] len;
        logic [`LINE_CNT_WIDTH-1:0] cnt;
        logic [`AXI_LEN_WIDTH-1:0]  len_max;
    } cmd_t;

    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`LINE_LEN_WIDTH-1:0] len;
        logic [`AXI_LEN_WIDTH-1:0]  len_max;
        flag_pair_t                 flags;
    } line_t;

endpackage

// ==== design/line_fifo.sv ====
// --------------------------------------
//  line_fifo
//  synchronous valid/ready ring buffer
// --------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "axi4_read_nd_cfg.svh"

module line_fifo #(
    parameter type data_t     = logic [7:0],
    parameter int  depth_log2 = `LINE_FIFO_DEPTH_LOG2
) (
    input  logic  clk,
    input  logic  reset,
    input  data_t s_data,
    input  logic  s_valid,
    output logic  s_ready,
    output data_t m_data,
    output logic  m_valid,
    input  logic  m_ready
);
    localparam int depth = 1 << depth_log2;

    data_t                 mem [depth];
    logic [depth_log2-1:0] wr_ptr;
    logic [depth_log2-1:0] rd_ptr;
    logic [depth_log2:0]   count;
    logic                  push;
    logic                  pop;

    // msb of the count set means full
    assign s_ready = !count[depth_log2];
    assign m_valid = (count != '0);
    assign m_data  = mem[rd_ptr];
    assign push    = s_valid && s_ready;
    assign pop     = m_valid && m_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= depth)
        else $error("line_fifo: count 0x%0h above depth", count);

endmodule

`default_nettype wire

// ==== design/address_generator_2d.sv ====
// --------------------------------------
//  address_generator_2d
//  walks a 2d command line by line and
//  emits one line record per line
// --------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "axi4_read_nd_cfg.svh"

module address_generator_2d (
    input  logic                    clk,
    input  logic                    reset,
    input  axi4_read_nd_pkg::cmd_t  s_cmd,
    input  logic                    s_valid,
    output logic                    s_ready,
    output axi4_read_nd_pkg::line_t m_line,
    output logic                    m_valid,
    input  logic                    m_ready
);
    axi4_read_nd_pkg::cmd_t     cmd;
    logic                       busy;
    logic [`AXI_ADDR_WIDTH-1:0] line_addr;
    logic [`LINE_CNT_WIDTH-1:0] line_idx;
    logic                       last_line;

    assign s_ready   = !busy;
    assign m_valid   = busy;
    assign last_line = (line_idx == cmd.cnt);

    always_comb begin
        m_line.addr        = line_addr;
        m_line.len         = cmd.len;
        m_line.len_max     = cmd.len_max;
        m_line.flags.first = (line_idx == '0);
        m_line.flags.last  = last_line;
    end

    // busy from command accept to the last line handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (s_valid && s_ready) begin
            busy <= 1'b1;
        end else if (m_valid && m_ready && last_line) begin
            busy <= 1'b0;
        end
    end

    // ----------------------------------------
    //  line walk
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            cmd       <= s_cmd;
            line_addr <= s_cmd.addr;
            line_idx  <= '0;
        end else if (m_valid && m_ready) begin
            // step is in bytes, added once per line
            line_addr <= line_addr + cmd.step;
            line_idx  <= line_idx + 1'b1;
        end
    end

    a_line_held: assert property (@(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_line))
        else $error("address_generator_2d: m_line changed while stalled, now 0x%0h", m_line);

endmodule

`default_nettype wire

// ==== design/burst_splitter.sv ====
// --------------------------------------
//  burst_splitter
//  cuts each line into AXI4 AR bursts and
//  queues the line for the data side
// --------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "axi4_read_nd_cfg.svh"

module burst_splitter (
    input  logic                       clk,
    input  logic                       reset,
    input  axi4_read_nd_pkg::line_t    s_line,
    input  logic                       s_valid,
    output logic                       s_ready,
    output logic [`AXI_ADDR_WIDTH-1:0] m_araddr,
    output logic [`AXI_LEN_WIDTH-1:0]  m_arlen,
    output logic                       m_arvalid,
    input  logic                       m_arready,
    output axi4_read_nd_pkg::line_t    q_line,
    output logic                       q_valid,
    input  logic                       q_ready
);
    logic                       s_fire;
    logic                       load;
    logic                       more;
    logic [`LINE_LEN_WIDTH-1:0] rem;
    logic [`AXI_ADDR_WIDTH-1:0] next_addr;
    logic [`AXI_LEN_WIDTH-1:0]  len_max;
    logic [`LINE_LEN_WIDTH-1:0] src_rem;
    logic [`AXI_ADDR_WIDTH-1:0] src_addr;
    logic [`AXI_LEN_WIDTH-1:0]  src_max;
    logic [`LINE_LEN_WIDTH-1:0] src_max_ext;
    logic                       src_split;
    logic [`AXI_ADDR_WIDTH-1:0] burst_bytes;

    // a new line only once the AR slot is empty
    assign s_ready = !m_arvalid && q_ready;
    assign q_valid = s_valid && !m_arvalid;
    assign q_line  = s_line;
    assign s_fire  = s_valid && s_ready;
    assign load    = s_fire || (m_arvalid && m_arready && more);

    // ----------------------------------------
    //  next burst source
    // ----------------------------------------

    // beats left minus one, either a fresh line or the remainder
    assign src_rem     = s_fire ? s_line.len : rem;
    assign src_addr    = s_fire ? s_line.addr : next_addr;
    assign src_max     = s_fire ? s_line.len_max : len_max;
    assign src_max_ext = {{(`LINE_LEN_WIDTH-`AXI_LEN_WIDTH){1'b0}}, src_max};
    assign src_split   = (src_rem > src_max_ext);
    assign burst_bytes = ({{(`AXI_ADDR_WIDTH-`AXI_LEN_WIDTH){1'b0}}, src_max} + 1'b1)
                         * `BEAT_BYTES;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_arvalid <= 1'b0;
            more      <= 1'b0;
        end else if (load) begin
            m_arvalid <= 1'b1;
            more      <= src_split;
        end else if (m_arready) begin
            m_arvalid <= 1'b0;
        end
    end

    // full bursts until the rest fits in one
    always_ff @(posedge clk) begin
        if (load) begin
            m_araddr  <= src_addr;
            m_arlen   <= src_split ? src_max : src_rem[`AXI_LEN_WIDTH-1:0];
            rem       <= src_rem - src_max_ext - 1'b1;
            next_addr <= src_addr + burst_bytes;
            len_max   <= src_max;
        end
    end

    a_arlen_in_limit: assert property (@(posedge clk) disable iff (reset)
        m_arvalid |-> m_arlen <= len_max)
        else $error("burst_splitter: m_arlen 0x%0h above max 0x%0h", m_arlen, len_max);

endmodule

`default_nettype wire

// ==== design/read_flagger.sv ====
// --------------------------------------
//  read_flagger
//  flags R beats by line and frame and
//  raises one completion per line
// --------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "axi4_read_nd_cfg.svh"

module read_flagger (
    input  logic                          clk,
    input  logic                          reset,
    input  axi4_read_nd_pkg::line_t       p_line,
    input  logic                          p_valid,
    output logic                          p_ready,
    input  logic [`AXI_DATA_WIDTH-1:0]    m_rdata,
    input  logic                          m_rlast,
    input  logic                          m_rvalid,
    output logic                          m_rready,
    output logic [`AXI_DATA_WIDTH-1:0]    s_rdata,
    output axi4_read_nd_pkg::beat_flags_t s_rflags,
    output logic                          s_rvalid,
    input  logic                          s_rready,
    output axi4_read_nd_pkg::flag_pair_t  s_cflags,
    output logic                          s_cvalid,
    input  logic                          s_cready
);
    logic [`LINE_LEN_WIDTH-1:0] beat_cnt;
    logic                       last_beat;
    logic                       hold;
    logic                       beat_fire;

    // line end comes from the beat count, rlast only closes bursts
    assign last_beat = (beat_cnt == p_line.len);
    // pending completion blocks the next line end
    assign hold      = s_cvalid && last_beat;
    assign m_rready  = s_rready && !hold;
    assign s_rvalid  = m_rvalid && !hold;
    assign s_rdata   = m_rdata;
    assign beat_fire = s_rvalid && s_rready;
    assign p_ready   = beat_fire && last_beat;

    always_comb begin
        s_rflags.beat.first = (beat_cnt == '0);
        s_rflags.beat.last  = last_beat;
        s_rflags.line       = p_line.flags;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        end
    end

    // completion for the line just finished
    always_ff @(posedge clk) begin
        if (reset) begin
            s_cvalid <= 1'b0;
        end else if (p_ready) begin
            s_cvalid <= 1'b1;
        end else if (s_cready) begin
            s_cvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (p_ready) begin
            s_cflags <= p_line.flags;
        end
    end

    a_data_has_line: assert property (@(posedge clk) disable iff (reset)
        m_rvalid |-> p_valid)
        else $error("read_flagger: m_rdata 0x%0h with empty line queue", m_rdata);

    // bursts never straddle two lines
    a_line_ends_burst: assert property (@(posedge clk) disable iff (reset)
        beat_fire && last_beat |-> m_rlast)
        else $error("read_flagger: line end at beat 0x%0h without m_rlast", beat_cnt);

endmodule

`default_nettype wire

// ==== design/axi4_read_nd.sv ====
// --------------------------------------
//  axi4_read_nd
//  AXI4 2d read core, command to flagged
//  data stream and line completions
// --------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "axi4_read_nd_cfg.svh"

module axi4_read_nd (
    input  logic                          clk,
    input  logic                          reset,
    input  axi4_read_nd_pkg::cmd_t        s_cmd,
    input  logic                          s_cmd_valid,
    output logic                          s_cmd_ready,
    output logic [`AXI_ADDR_WIDTH-1:0]    m_araddr,
    output logic [`AXI_LEN_WIDTH-1:0]     m_arlen,
    output logic                          m_arvalid,
    input  logic                          m_arready,
    input  logic [`AXI_DATA_WIDTH-1:0]    m_rdata,
    input  logic                          m_rlast,
    input  logic                          m_rvalid,
    output logic                          m_rready,
    output logic [`AXI_DATA_WIDTH-1:0]    s_rdata,
    output axi4_read_nd_pkg::beat_flags_t s_rflags,
    output logic                          s_rvalid,
    input  logic                          s_rready,
    output axi4_read_nd_pkg::flag_pair_t  s_cflags,
    output logic                          s_cvalid,
    input  logic                          s_cready
);
    axi4_read_nd_pkg::cmd_t  cmd_data;
    logic                    cmd_valid;
    logic                    cmd_ready;
    axi4_read_nd_pkg::line_t gen_line;
    logic                    gen_valid;
    logic                    gen_ready;
    axi4_read_nd_pkg::line_t q_line;
    logic                    q_valid;
    logic                    q_ready;
    axi4_read_nd_pkg::line_t p_line;
    logic                    p_valid;
    logic                    p_ready;

    // ----------------------------------------
    //  command and address side
    // ----------------------------------------

    line_fifo #(
        .data_t     (axi4_read_nd_pkg::cmd_t),
        .depth_log2 (`CMD_FIFO_DEPTH_LOG2)
    ) i_cmd_fifo (
        .clk (clk), .reset (reset),
        .s_data (s_cmd), .s_valid (s_cmd_valid), .s_ready (s_cmd_ready),
        .m_data (cmd_data), .m_valid (cmd_valid), .m_ready (cmd_ready)
    );

    address_generator_2d i_address_generator_2d (
        .clk (clk), .reset (reset),
        .s_cmd (cmd_data), .s_valid (cmd_valid), .s_ready (cmd_ready),
        .m_line (gen_line), .m_valid (gen_valid), .m_ready (gen_ready)
    );

    burst_splitter i_burst_splitter (
        .clk (clk), .reset (reset),
        .s_line (gen_line), .s_valid (gen_valid), .s_ready (gen_ready),
        .m_araddr (m_araddr), .m_arlen (m_arlen),
        .m_arvalid (m_arvalid), .m_arready (m_arready),
        .q_line (q_line), .q_valid (q_valid), .q_ready (q_ready)
    );

    // ----------------------------------------
    //  data side
    // ----------------------------------------

    line_fifo #(
        .data_t     (axi4_read_nd_pkg::line_t),
        .depth_log2 (`LINE_FIFO_DEPTH_LOG2)
    ) i_line_fifo (
        .clk (clk), .reset (reset),
        .s_data (q_line), .s_valid (q_valid), .s_ready (q_ready),
        .m_data (p_line), .m_valid (p_valid), .m_ready (p_ready)
    );

    read_flagger i_read_flagger (
        .clk (clk), .reset (reset),
        .p_line (p_line), .p_valid (p_valid), .p_ready (p_ready),
        .m_rdata (m_rdata), .m_rlast (m_rlast),
        .m_rvalid (m_rvalid), .m_rready (m_rready),
        .s_rdata (s_rdata), .s_rflags (s_rflags),
        .s_rvalid (s_rvalid), .s_rready (s_rready),
        .s_cflags (s_cflags), .s_cvalid (s_cvalid), .s_cready (s_cready)
    );

endmodule

`default_nettype wire

// ==== test/axi4_mem_model.sv ====
// --------------------------------------
//  axi4_mem_model
//  AXI4 read slave, data is the byte
//  address, random AR and R stalls
// --------------------------------------

`timescale 1ns/1ps
`include "axi4_read_nd_cfg.svh"

module axi4_mem_model (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    input  logic [`AXI_LEN_WIDTH-1:0]  arlen,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [`AXI_DATA_WIDTH-1:0] rdata,
    output logic                       rlast,
    output logic                       rvalid,
    input  logic                       rready
);
    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic                       last;
    } beat_t;

    // beats of all accepted bursts, oldest first
    beat_t beats [$];
    beat_t beat;

    initial begin
        arready = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        rvalid  = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rdata   <= '0;
            beats.delete();
        end else begin
            arready <= ($urandom % 4) != 0;
            if (arvalid && arready) begin
                for (int i = 0; i <= int'(arlen); i++) begin
                    beat.addr = araddr + i * `BEAT_BYTES;
                    beat.last = (i == int'(arlen));
                    beats.push_back(beat);
                end
            end
            // R slot free, present the next beat or stall
            if (!rvalid || rready) begin
                if (beats.size() != 0 && ($urandom % 3) != 0) begin
                    beat = beats.pop_front();
                    rdata  <= beat.addr;
                    rlast  <= beat.last;
                    rvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== test/tb_axi4_read_nd.sv ====
// --------------------------------------
//  tb_axi4_read_nd
//  three 2d read commands against a
//  stalling AXI4 memory model
// --------------------------------------

`timescale 1ns/1ps
`include "axi4_read_nd_cfg.svh"

module tb_axi4_read_nd;
    // 57 data beats in total, about 70 cycles allowed per beat
    localparam int total_beats    = 57;
    localparam int total_lines    = 8;
    localparam int timeout_cycles = 4000;

    logic clk = 1'b0;
    logic reset;
    axi4_read_nd_pkg::cmd_t        s_cmd;
    logic                          s_cmd_valid;
    logic                          s_cmd_ready;
    logic [`AXI_ADDR_WIDTH-1:0]    m_araddr;
    logic [`AXI_LEN_WIDTH-1:0]     m_arlen;
    logic                          m_arvalid;
    logic                          m_arready;
    logic [`AXI_DATA_WIDTH-1:0]    m_rdata;
    logic                          m_rlast;
    logic                          m_rvalid;
    logic                          m_rready;
    logic [`AXI_DATA_WIDTH-1:0]    s_rdata;
    axi4_read_nd_pkg::beat_flags_t s_rflags;
    logic                          s_rvalid;
    logic                          s_rready;
    axi4_read_nd_pkg::flag_pair_t  s_cflags;
    logic                          s_cvalid;
    logic                          s_cready;

    axi4_read_nd_pkg::cmd_t        cmds [3];
    logic [1:0]                    r_cmd, ar_cmd, c_cmd;
    logic [`LINE_CNT_WIDTH-1:0]    r_line, ar_line, c_line;
    logic [`LINE_LEN_WIDTH-1:0]    r_beat, ar_beat;
    logic [`LINE_LEN_WIDTH:0]      ar_rem;
    logic [`AXI_LEN_WIDTH:0]       ar_max;
    logic [`AXI_DATA_WIDTH-1:0]    exp_rdata;
    logic [`AXI_ADDR_WIDTH-1:0]    exp_araddr;
    logic [`AXI_LEN_WIDTH-1:0]     exp_arlen;
    axi4_read_nd_pkg::beat_flags_t exp_rflags;
    axi4_read_nd_pkg::flag_pair_t  exp_cflags;
    logic                          cmd_seen;
    int beats_seen, bursts_seen, lines_read, lines_done, cmds_done;
    int errors, err_base, cycles;

    always #50 clk = ~clk;

    axi4_read_nd i_dut (.*);

    axi4_mem_model i_mem (
        .clk (clk), .reset (reset),
        .araddr (m_araddr), .arlen (m_arlen), .arvalid (m_arvalid), .arready (m_arready),
        .rdata (m_rdata), .rlast (m_rlast), .rvalid (m_rvalid), .rready (m_rready)
    );

    // ----------------------------------------
    //  expected values from the command list
    // ----------------------------------------

    always_comb begin
        exp_rdata = cmds[r_cmd].addr + r_line * cmds[r_cmd].step + r_beat * `BEAT_BYTES;
        exp_rflags.beat.first = (r_beat == '0);
        exp_rflags.beat.last  = (r_beat == cmds[r_cmd].len);
        exp_rflags.line.first = (r_line == '0);
        exp_rflags.line.last  = (r_line == cmds[r_cmd].cnt);
        // beats still to request in this line, and the burst limit
        ar_rem     = cmds[ar_cmd].len + 1'b1 - ar_beat;
        ar_max     = cmds[ar_cmd].len_max + 1'b1;
        exp_araddr = cmds[ar_cmd].addr + ar_line * cmds[ar_cmd].step + ar_beat * `BEAT_BYTES;
        exp_arlen  = (ar_rem > ar_max) ? cmds[ar_cmd].len_max : 8'(ar_rem - 1'b1);
        exp_cflags.first = (c_line == '0);
        exp_cflags.last  = (c_line == cmds[c_cmd].cnt);
    end

    always @(posedge clk) begin
        if (reset) begin
            r_cmd <= '0; r_line <= '0; r_beat <= '0; beats_seen <= 0; lines_read <= 0;
        end else if (s_rvalid && s_rready) begin
            beats_seen <= beats_seen + 1;
            r_beat     <= exp_rflags.beat.last ? '0 : r_beat + 1'b1;
            if (exp_rflags.beat.last) begin
                lines_read <= lines_read + 1;
                r_line     <= exp_rflags.line.last ? '0 : r_line + 1'b1;
                r_cmd      <= r_cmd + exp_rflags.line.last;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            ar_cmd <= '0; ar_line <= '0; ar_beat <= '0; bursts_seen <= 0;
        end else if (m_arvalid && m_arready) begin
            bursts_seen <= bursts_seen + 1;
            if (ar_rem <= ar_max) begin
                ar_beat <= '0;
                ar_line <= (ar_line == cmds[ar_cmd].cnt) ? '0 : ar_line + 1'b1;
                ar_cmd  <= ar_cmd + (ar_line == cmds[ar_cmd].cnt);
            end else begin
                ar_beat <= ar_beat + ar_max;
            end
        end
    end

    // completions, one report line per finished command
    always @(posedge clk) begin
        if (reset) begin
            c_cmd <= '0; c_line <= '0; lines_done <= 0; cmds_done <= 0; err_base <= 0;
        end else if (s_cvalid && s_cready) begin
            lines_done <= lines_done + 1;
            c_line     <= exp_cflags.last ? '0 : c_line + 1'b1;
            if (exp_cflags.last) begin
                $display("command %0d: %0d lines done, %0d errors",
                         c_cmd, cmds[c_cmd].cnt + 1, errors - err_base);
                err_base  <= errors;
                cmds_done <= cmds_done + 1;
                c_cmd     <= c_cmd + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            cmd_seen <= 1'b0;
        end else if (s_cmd_valid && s_cmd_ready) begin
            cmd_seen <= 1'b1;
        end
    end

    // ----------------------------------------
    //  checks
    // ----------------------------------------

    idle_before_cmd: assert property (@(posedge clk) disable iff (reset)
        !cmd_seen |-> !m_arvalid && !s_rvalid && !s_cvalid)
        else begin
            errors++;
            $display("outputs active before the first command was accepted");
        end

    rdata_ok: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && s_rready |-> r_cmd < 3 && s_rdata == exp_rdata)
        else begin
            errors++;
            $display("error: s_rdata 0x%08h, expected 0x%08h", $sampled(s_rdata),
                     $sampled(exp_rdata));
        end

    rflags_ok: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && s_rready |-> s_rflags == exp_rflags)
        else begin
            errors++;
            $display("error: s_rflags 0x%0h, expected 0x%0h", $sampled(s_rflags),
                     $sampled(exp_rflags));
        end

    // R beats pass straight through, taken on both sides in the same cycle
    r_pass_through: assert property (@(posedge clk) disable iff (reset)
        (m_rvalid && m_rready) == (s_rvalid && s_rready))
        else begin
            errors++;
            $display("error: m_rready 0x%0h, m_rvalid 0x%0h, s_rvalid 0x%0h, s_rready 0x%0h",
                     $sampled(m_rready), $sampled(m_rvalid), $sampled(s_rvalid),
                     $sampled(s_rready));
        end

    araddr_ok: assert property (@(posedge clk) disable iff (reset)
        m_arvalid && m_arready |-> ar_cmd < 3 && m_araddr == exp_araddr)
        else begin
            errors++;
            $display("error: m_araddr 0x%08h, expected 0x%08h", $sampled(m_araddr),
                     $sampled(exp_araddr));
        end

    arlen_ok: assert property (@(posedge clk) disable iff (reset)
        m_arvalid && m_arready |-> m_arlen == exp_arlen)
        else begin
            errors++;
            $display("error: m_arlen 0x%02h, expected 0x%02h", $sampled(m_arlen),
                     $sampled(exp_arlen));
        end

    // a completion only follows the last beat of its line
    cflags_ok: assert property (@(posedge clk) disable iff (reset)
        s_cvalid && s_cready |-> lines_done < lines_read && s_cflags == exp_cflags)
        else begin
            errors++;
            $display("error: s_cflags 0x%0h, expected 0x%0h", $sampled(s_cflags),
                     $sampled(exp_cflags));
        end

    r_held: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rflags))
        else begin
            errors++;
            $display("read beat changed or dropped while stalled");
        end

    c_held: assert property (@(posedge clk) disable iff (reset)
        s_cvalid && !s_cready |=> s_cvalid && $stable(s_cflags))
        else begin
            errors++;
            $display("completion changed or dropped while stalled");
        end

    // ----------------------------------------
    //  stimulus
    // ----------------------------------------

    always @(posedge clk) begin
        s_rready <= ($urandom % 4) != 0;
        s_cready <= ($urandom % 3) != 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout after %0d cycles, %0d of 3 commands finished", cycles, cmds_done);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic send_cmd(input axi4_read_nd_pkg::cmd_t c);
        s_cmd       <= c;
        s_cmd_valid <= 1'b1;
        @(negedge clk);
        while (!s_cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        s_cmd_valid <= 1'b0;
    endtask

    initial begin
        void'($urandom(7197));
        reset = 1'b1;
        s_cmd = '0;
        s_cmd_valid = 1'b0;
        s_rready = 1'b0;
        s_cready = 1'b0;
        errors = 0;
        cycles = 0;
        cmds[0] = '{addr: 32'h1000, step: 32'h40, len: 12'd4, cnt: 12'd0, len_max: 8'd3};
        cmds[1] = '{addr: 32'h2000, step: 32'h20, len: 12'd7, cnt: 12'd2, len_max: 8'd7};
        cmds[2] = '{addr: 32'h3000, step: 32'h100, len: 12'd6, cnt: 12'd3, len_max: 8'd1};
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        send_cmd(cmds[0]);
        send_cmd(cmds[1]);
        send_cmd(cmds[2]);
        while (cmds_done < 3) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        if (beats_seen != total_beats || lines_done != total_lines) begin
            errors++;
            $display("stream ended with %0d beats and %0d completions, expected %0d and %0d",
                     beats_seen, lines_done, total_beats, total_lines);
        end
        $display("beats %0d, bursts %0d, completions %0d, errors %0d",
                 beats_seen, bursts_seen, lines_done, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/axi4_read_nd_pkg.sv
design/line_fifo.sv
design/address_generator_2d.sv
design/burst_splitter.sv
design/read_flagger.sv
design/axi4_read_nd.sv
test/axi4_mem_model.sv
test/tb_axi4_read_nd.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the 2d reader testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_axi4_read_nd -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$log"; then
    exit 1
fi
exit 0
